// File: build.f
fetch_types_pkg.sv
core_bus_pkg.sv
line_predecoder.sv
branch_predictor.sv
fetch_request_stage.sv
fetch_buffer.sv
inst_fetch_top.sv
tb_fetch_checks.sv
tb_inst_fetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the fetch front end testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_inst_fetch \
  -f build.f -o sim_tb_inst_fetch
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_inst_fetch > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1

// File: tb_inst_fetch.sv
/*
  testbench of the fetch front end with an APB slave model
  slave memory returns the address itself except at placed program words
  pready comes after 0 to 3 wait states
*/
`timescale 1ns/1ns

module tb_inst_fetch;

  import fetch_types_pkg::*;
  import core_bus_pkg::*;

  localparam int clock_period = 4;
  // stimulus length in cycles for the watchdog
  localparam int test_cycles = 300;
  localparam logic [31:0] jal_pc = 32'h0000_1108;
  localparam logic [31:0] jal_target = 32'h0000_1040;
  localparam logic [31:0] jal_line = 32'h0000_1100;
  localparam logic [31:0] far_pc = 32'h0000_2000;

  logic                       clock;
  logic                       reset;
  apb_req_t                   apb_req;
  apb_rsp_t                   apb_rsp = '0;
  retire_t [retire_width-1:0] retire;
  redirect_t                  redirect;
  fetch_packet_t              out_packet;
  logic                       out_valid;
  logic                       out_ready = 1'b0;
  logic                       check_failed;

  // slave and decode model state
  logic [31:0] rng_state = 32'he610;
  logic [31:0] line_base = '0;
  logic [1:0]  wait_left = '0;
  logic        pready_next;
  logic        ready_next;
  // 0 random, 1 held low, 2 held high
  logic [1:0]  ready_mode;

  logic [31:0] prog_addr [4];
  logic [31:0] prog_word [4];
  int          prog_count;

  inst_fetch_top u_inst_fetch_top (
    .clock      (clock),
    .reset      (reset),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .retire     (retire),
    .redirect   (redirect),
    .out_packet (out_packet),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

  tb_fetch_checks u_fetch_checks (
    .clock      (clock),
    .reset      (reset),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .retire     (retire),
    .redirect   (redirect),
    .out_packet (out_packet),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .failed     (check_failed)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] word;
    word = addr;
    for (int p = 0; p < prog_count; p++) begin
      if (prog_addr[p] == addr) begin
        word = prog_word[p];
      end
    end
    return word;
  endfunction

  function automatic logic [127:0] read_line(input logic [31:0] addr);
    logic [127:0] data;
    for (int i = 0; i < fetch_width; i++) begin
      data[32*i +: 32] = mem_word(addr + 32'(4 * i));
    end
    return data;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic run_cycles(input int n);
    repeat (n) step();
  endtask

  task automatic place_word(input logic [31:0] addr, input logic [31:0] word);
    prog_addr[prog_count] = addr;
    prog_word[prog_count] = word;
    prog_count++;
  endtask

  task automatic retire_branch(input logic [31:0] pc, input logic taken,
                               input logic [31:0] target);
    retire[0].valid = 1'b1;
    retire[0].pc = pc;
    retire[0].is_branch = 1'b1;
    retire[0].taken = taken;
    retire[0].target = target;
    step();
    retire = '0;
  endtask

  // one cycle redirect then a wait for the fetch from the new address
  task automatic redirect_to(input logic [31:0] addr);
    int n;
    redirect.valid = 1'b1;
    redirect.pc = addr;
    step();
    redirect = '0;
    n = 0;
    @(negedge clock);
    while (!(apb_req.psel && !apb_req.penable) && n < 20) begin
      n++;
      @(negedge clock);
    end
    if (!(apb_req.psel && !apb_req.penable)) begin
      abort_run("no APB setup cycle within 20 cycles of a redirect");
    end else begin
      step();
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    #(40 * test_cycles * clock_period);
    abort_run("watchdog expired before the stimulus finished");
  end

  always @(posedge check_failed) begin
    abort_run("a port check failed");
  end

  // APB slave and decode ready sampled at the edge and driven 1 ns later
  always @(posedge clock) begin
    rng_state = xorshift(rng_state);
    if (reset) begin
      pready_next = 1'b0;
    end else if (apb_req.psel && !apb_req.penable) begin
      wait_left = rng_state[1:0];
      line_base = apb_req.paddr;
      pready_next = (rng_state[1:0] == 2'd0);
    end else if (apb_req.psel && !apb_rsp.pready) begin
      wait_left = wait_left - 2'd1;
      pready_next = (wait_left == 2'd0);
    end else begin
      pready_next = 1'b0;
    end
    case (ready_mode)
      2'd1: ready_next = 1'b0;
      2'd2: ready_next = 1'b1;
      default: ready_next = rng_state[9] | rng_state[10];
    endcase
    #1;
    apb_rsp.pready = pready_next;
    apb_rsp.prdata = read_line(line_base);
    out_ready = ready_next;
  end

  initial begin
    reset = 1'b1;
    retire = '0;
    redirect = '0;
    ready_mode = 2'd0;
    prog_count = 0;
    // jal in slot 2 of its line
    place_word(jal_pc, 32'h0400_006f);
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;
    run_cycles(60);
    // taken twice brings the counter to 3
    retire_branch(jal_pc, 1'b1, jal_target);
    retire_branch(jal_pc, 1'b1, jal_target);
    redirect_to(jal_line);
    run_cycles(40);
    // not taken twice drops it below 2
    retire_branch(jal_pc, 1'b0, jal_target);
    retire_branch(jal_pc, 1'b0, jal_target);
    redirect_to(jal_line);
    run_cycles(40);
    redirect_to(far_pc);
    run_cycles(20);
    // decode stall fills the buffer
    ready_mode = 2'd1;
    run_cycles(30);
    ready_mode = 2'd2;
    run_cycles(30);
    ready_mode = 2'd0;
    run_cycles(30);
    if (check_failed) begin
      abort_run("a port check failed at the end of the run");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

// File: tb_fetch_checks.sv
/*
  reference model of the fetch front end checked at the ports
  one retire update per predictor index per cycle
*/
`timescale 1ns/1ns

module tb_fetch_checks (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  core_bus_pkg::apb_req_t                                  apb_req,
  input  core_bus_pkg::apb_rsp_t                                  apb_rsp,
  input  core_bus_pkg::retire_t [core_bus_pkg::retire_width-1:0]  retire,
  input  core_bus_pkg::redirect_t                                 redirect,
  input  fetch_types_pkg::fetch_packet_t                          out_packet,
  input  logic                                                    out_valid,
  input  logic                                                    out_ready,
  output logic                                                    failed
);

  import fetch_types_pkg::*;
  import core_bus_pkg::*;

  // predictor model
  logic [1:0]  bht [bht_entries];
  logic        btb_valid [btb_entries];
  logic [31:0] btb_tag [btb_entries];
  logic [31:0] btb_target [btb_entries];

  // packets in the packet register and buffer with the oldest at exp_rd
  fetch_packet_t exp_q [8];
  fetch_packet_t exp_head;
  logic [2:0]  exp_rd;
  logic [3:0]  exp_count;
  logic [31:0] exp_pc;
  logic [31:0] line_addr;
  logic        stale;
  logic        prev_open;
  logic        after_reset;
  logic        setup;
  logic        done;
  logic        pop;

  logic fail_first = 1'b0;
  logic fail_reset = 1'b0;
  logic fail_paddr = 1'b0;
  logic fail_stable = 1'b0;
  logic fail_enable = 1'b0;
  logic fail_write = 1'b0;
  logic fail_extra = 1'b0;
  logic fail_missing = 1'b0;
  logic fail_packet = 1'b0;
  logic fail_stall = 1'b0;

  assign setup = apb_req.psel && !apb_req.penable;
  assign done = apb_req.psel && apb_req.penable && apb_rsp.pready;
  assign pop = out_valid && out_ready;
  assign exp_head = exp_q[exp_rd];
  assign failed = fail_first | fail_reset | fail_paddr | fail_stable | fail_enable |
                  fail_write | fail_extra | fail_missing | fail_packet | fail_stall;

  // counter at 2 or more and a tag hit
  function automatic logic predicted_taken(input logic [31:0] pc);
    return bht[pc[7:2]][1] && btb_valid[pc[5:2]] && (btb_tag[pc[5:2]] == pc);
  endfunction

  // expected line cut after the first predicted taken slot
  function automatic fetch_packet_t expected_line(input logic [31:0] base,
                                                  input logic [127:0] data);
    fetch_packet_t pkt;
    logic          found;
    logic [31:0]   pc;
    logic [6:0]    op;
    found = 1'b0;
    for (int i = 0; i < fetch_width; i++) begin
      pc = base + 32'(4 * i);
      op = data[32*i +: 7];
      pkt[i].valid = !found;
      pkt[i].pc = pc;
      pkt[i].inst = data[32*i +: 32];
      pkt[i].pred_taken = !found && predicted_taken(pc) &&
                          (op == rv32_op_branch || op == rv32_op_jal || op == rv32_op_jalr);
      pkt[i].pred_addr = pkt[i].pred_taken ? btb_target[pc[5:2]] : 32'd0;
      if (pkt[i].pred_taken) begin
        found = 1'b1;
      end
    end
    return pkt;
  endfunction

  function automatic logic [31:0] expected_next(input fetch_packet_t pkt,
                                                input logic [31:0] base);
    logic [31:0] next;
    next = base + 32'd16;
    for (int i = fetch_width - 1; i >= 0; i--) begin
      if (pkt[i].pred_taken) begin
        next = pkt[i].pred_addr;
      end
    end
    return next;
  endfunction

  always_ff @(posedge clock) begin
    after_reset <= reset;
    if (reset) begin
      exp_pc <= reset_pc;
      exp_rd <= '0;
      exp_count <= '0;
      stale <= 1'b0;
      prev_open <= 1'b0;
      for (int e = 0; e < bht_entries; e++) begin
        bht[e] <= 2'd1;
      end
      for (int e = 0; e < btb_entries; e++) begin
        btb_valid[e] <= 1'b0;
      end
    end else begin
      prev_open <= apb_req.psel && !done;
      if (setup) begin
        line_addr <= exp_pc;
      end
      if (redirect.valid) begin
        // fetched lines are gone and an open transfer returns stale data
        exp_pc <= redirect.pc;
        exp_rd <= '0;
        exp_count <= '0;
        stale <= apb_req.psel && !done;
      end else begin
        if (done && !stale) begin
          exp_q[exp_rd + exp_count[2:0]] <= expected_line(line_addr, apb_rsp.prdata);
          exp_pc <= expected_next(expected_line(line_addr, apb_rsp.prdata), line_addr);
        end
        if (done) begin
          stale <= 1'b0;
        end
        exp_rd <= exp_rd + 3'(pop);
        exp_count <= exp_count + 4'(done && !stale) - 4'(pop);
      end
      // training moves one step toward the outcome
      for (int r = 0; r < retire_width; r++) begin
        if (retire[r].valid && retire[r].is_branch) begin
          if (retire[r].taken) begin
            bht[retire[r].pc[7:2]] <= (bht[retire[r].pc[7:2]] == 2'd3) ? 2'd3 :
                                      bht[retire[r].pc[7:2]] + 2'd1;
            btb_valid[retire[r].pc[5:2]] <= 1'b1;
            btb_tag[retire[r].pc[5:2]] <= retire[r].pc;
            btb_target[retire[r].pc[5:2]] <= retire[r].target;
          end else begin
            bht[retire[r].pc[7:2]] <= (bht[retire[r].pc[7:2]] == 2'd0) ? 2'd0 :
                                      bht[retire[r].pc[7:2]] - 2'd1;
          end
        end
      end
    end
  end

  // nothing requested or offered while reset holds
  assert property (@(posedge clock)
    (reset && after_reset) |-> !(apb_req.psel || out_valid))
    else begin
      $display("APB select or output valid was high during reset");
      fail_reset <= 1'b1;
    end

  assert property (@(posedge clock) disable iff (reset) after_reset |-> (setup && !out_valid))
    else begin
      $display("no APB setup cycle right after reset, or output valid too early");
      fail_first <= 1'b1;
    end

  assert property (@(posedge clock) disable iff (reset) setup |-> (apb_req.paddr == exp_pc))
    else begin
      $display("CHECK FAILED paddr got %h expected %h", apb_req.paddr, exp_pc);
      fail_paddr <= 1'b1;
    end

  // address held through the access phase
  assert property (@(posedge clock) disable iff (reset)
    (apb_req.psel && apb_req.penable) |-> (apb_req.paddr == line_addr))
    else begin
      $display("CHECK FAILED paddr got %h expected %h", apb_req.paddr, line_addr);
      fail_stable <= 1'b1;
    end

  assert property (@(posedge clock) disable iff (reset)
    apb_req.penable |-> (apb_req.psel && prev_open))
    else begin
      $display("penable was set without a setup cycle before it");
      fail_enable <= 1'b1;
    end

  assert property (@(posedge clock) disable iff (reset) apb_req.psel |-> !apb_req.pwrite)
    else begin
      $display("the fetch unit started an APB write");
      fail_write <= 1'b1;
    end

  assert property (@(posedge clock) disable iff (reset) out_valid |-> (exp_count != 4'd0))
    else begin
      $display("decode was offered a packet that was never fetched");
      fail_extra <= 1'b1;
    end

  // at most one packet waits in the packet register
  assert property (@(posedge clock) disable iff (reset) (exp_count >= 4'd2) |-> out_valid)
    else begin
      $display("fetched packets were held back from decode");
      fail_missing <= 1'b1;
    end

  assert property (@(posedge clock) disable iff (reset) pop |-> (out_packet == exp_head))
    else begin
      $display("CHECK FAILED out_packet got %h expected %h", out_packet, exp_head);
      fail_packet <= 1'b1;
    end

  // buffer full and packet register full
  assert property (@(posedge clock) disable iff (reset)
    (exp_count == 4'd5 && !out_ready) |-> !setup)
    else begin
      $display("an APB transfer started while the buffer and packet register were full");
      fail_stall <= 1'b1;
    end

endmodule

// File: inst_fetch_top.sv
/*
  fetch front end, request stage plus packet buffer
  a redirect flushes both stages in the same cycle
*/
`timescale 1ns/1ns

module inst_fetch_top (
  input  logic                                                    clock,
  input  logic                                                    reset,
  output core_bus_pkg::apb_req_t                                  apb_req,
  input  core_bus_pkg::apb_rsp_t                                  apb_rsp,
  input  core_bus_pkg::retire_t [core_bus_pkg::retire_width-1:0]  retire,
  input  core_bus_pkg::redirect_t                                 redirect,
  output fetch_types_pkg::fetch_packet_t                          out_packet,
  output logic                                                    out_valid,
  input  logic                                                    out_ready
);

  import fetch_types_pkg::*;

  // packet register to buffer
  fetch_packet_t packet;
  logic          packet_valid;
  logic          packet_ready;

  fetch_request_stage u_fetch_request_stage (
    .clock        (clock),
    .reset        (reset),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .retire       (retire),
    .redirect     (redirect),
    .packet       (packet),
    .packet_valid (packet_valid),
    .packet_ready (packet_ready)
  );

  fetch_buffer u_fetch_buffer (
    .clock      (clock),
    .reset      (reset),
    .flush      (redirect.valid),
    .in_packet  (packet),
    .in_valid   (packet_valid),
    .in_ready   (packet_ready),
    .out_packet (out_packet),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

endmodule

// File: fetch_buffer.sv
/*
  circular FIFO of fetch packets in front of decode
  flush empties it in one cycle, a write in the same cycle is lost
*/
`timescale 1ns/1ns

module fetch_buffer (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            flush,
  input  fetch_types_pkg::fetch_packet_t  in_packet,
  input  logic                            in_valid,
  output logic                            in_ready,
  output fetch_types_pkg::fetch_packet_t  out_packet,
  output logic                            out_valid,
  input  logic                            out_ready
);

  import fetch_types_pkg::*;

  fetch_packet_t mem [fetch_buffer_depth];
  logic [buffer_ptr_bits-1:0] rd_ptr;
  logic [buffer_ptr_bits-1:0] wr_ptr;
  // one extra bit to tell full from empty
  logic [buffer_ptr_bits:0]   count;
  logic full;
  logic push;
  logic pop;

  assign full = count[buffer_ptr_bits];
  assign wr_ptr = rd_ptr + count[buffer_ptr_bits-1:0];
  assign out_valid = (count != '0);
  assign out_packet = mem[rd_ptr];
  assign pop = out_valid && out_ready;
  // full but decode frees the head this cycle
  assign in_ready = !full || pop;
  assign push = in_valid && in_ready;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= in_packet;
    end
  end

  // refused packet stays with the request stage
  assert property (@(posedge clock) disable iff (reset)
    (in_valid && full && !pop && !flush) |=> (in_valid && $stable(in_packet)))
    else $error("packet taken or lost while the buffer was full");

endmodule

// File: fetch_request_stage.sv
/*
  fetch address register, APB read master and packet register
  a setup cycle waits for a free or draining packet register
  so psel follows packet_ready combinationally
  redirect pc must be word aligned
*/
`timescale 1ns/1ns

module fetch_request_stage (
  input  logic                                                    clock,
  input  logic                                                    reset,
  output core_bus_pkg::apb_req_t                                  apb_req,
  input  core_bus_pkg::apb_rsp_t                                  apb_rsp,
  input  core_bus_pkg::retire_t [core_bus_pkg::retire_width-1:0]  retire,
  input  core_bus_pkg::redirect_t                                 redirect,
  output fetch_types_pkg::fetch_packet_t                          packet,
  output logic                                                    packet_valid,
  input  logic                                                    packet_ready
);

  import fetch_types_pkg::*;

  // idle also covers the setup cycle
  typedef enum logic {st_idle, st_access} fetch_state_t;

  fetch_state_t state;
  logic [31:0] fetch_pc;
  logic [31:0] xfer_addr;
  logic [31:0] next_pc;
  logic        drop;
  logic        can_start;
  logic        setup;
  logic        done;
  logic        accept;
  logic [fetch_width-1:0][31:0] slot_pc;
  logic [fetch_width-1:0][31:0] slot_inst;
  logic [fetch_width-1:0][31:0] target;
  logic [fetch_width-1:0]       is_branch;
  logic [fetch_width-1:0]       hit_taken;
  fetch_packet_t line_packet;

  line_predecoder u_line_predecoder (
    .line      (apb_rsp.prdata),
    .base_pc   (xfer_addr),
    .slot_pc   (slot_pc),
    .slot_inst (slot_inst),
    .is_branch (is_branch)
  );

  branch_predictor u_branch_predictor (
    .clock     (clock),
    .reset     (reset),
    .slot_pc   (slot_pc),
    .retire    (retire),
    .hit_taken (hit_taken),
    .target    (target)
  );

  // register empty or draining this cycle
  assign can_start = !packet_valid || packet_ready;
  assign setup = !reset && (state == st_idle) && can_start;
  assign done = (state == st_access) && apb_rsp.pready;
  // stale data is dropped even when the redirect lands in the pready cycle
  assign accept = done && !drop && !redirect.valid;

  assign apb_req.psel = setup || (state == st_access);
  assign apb_req.penable = (state == st_access);
  assign apb_req.pwrite = 1'b0;
  // access holds the address so a redirect cannot move paddr mid transfer
  assign apb_req.paddr = (state == st_access) ? xfer_addr : fetch_pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      fetch_pc <= reset_pc;
      drop <= 1'b0;
    end else begin
      if (setup) begin
        state <= st_access;
      end else if (done) begin
        state <= st_idle;
      end
      if (redirect.valid) begin
        fetch_pc <= redirect.pc;
      end else if (accept) begin
        fetch_pc <= next_pc;
      end
      // transfer in flight when the redirect came
      if (done) begin
        drop <= 1'b0;
      end else if (redirect.valid && apb_req.psel) begin
        drop <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (setup) begin
      xfer_addr <= fetch_pc;
    end
  end

  // first predicted taken slot ends the line
  always_comb begin : build_line
    logic found;
    found = 1'b0;
    next_pc = xfer_addr + 32'd16;
    for (int i = 0; i < fetch_width; i++) begin
      line_packet[i].valid = !found;
      line_packet[i].pc = slot_pc[i];
      line_packet[i].inst = slot_inst[i];
      line_packet[i].pred_taken = !found && is_branch[i] && hit_taken[i];
      line_packet[i].pred_addr = line_packet[i].pred_taken ? target[i] : 32'd0;
      if (line_packet[i].pred_taken) begin
        next_pc = target[i];
        found = 1'b1;
      end
    end
  end

  // packet register toward the buffer
  always_ff @(posedge clock) begin
    if (reset) begin
      packet_valid <= 1'b0;
    end else if (redirect.valid) begin
      packet_valid <= 1'b0;
    end else if (accept) begin
      packet_valid <= 1'b1;
    end else if (packet_ready) begin
      packet_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      packet <= line_packet;
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    (apb_req.psel && !(apb_req.penable && apb_rsp.pready)) |=> $stable(apb_req.paddr))
    else $error("paddr changed during a transfer");

  assert property (@(posedge clock) disable iff (reset)
    apb_req.penable |-> $past(apb_req.psel && !(apb_req.penable && apb_rsp.pready)))
    else $error("penable without a preceding setup cycle");

endmodule

// File: branch_predictor.sv
/*
  bimodal 2-bit counters plus a direct mapped target buffer
  two retire entries on the same table index in one cycle: the higher one wins
  lookup is combinational on slot_pc
*/
`timescale 1ns/1ns

module branch_predictor (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  logic [fetch_types_pkg::fetch_width-1:0][31:0]           slot_pc,
  input  core_bus_pkg::retire_t [core_bus_pkg::retire_width-1:0]  retire,
  output logic [fetch_types_pkg::fetch_width-1:0]                 hit_taken,
  output logic [fetch_types_pkg::fetch_width-1:0][31:0]           target
);

  import fetch_types_pkg::*;
  import core_bus_pkg::*;

  // counter tables
  logic [1:0]  bht_count [bht_entries];
  logic        btb_valid [btb_entries];
  logic [31:0] btb_tag [btb_entries];
  logic [31:0] btb_target [btb_entries];

  logic [retire_width-1:0][bht_index_bits-1:0] retire_bht_idx;
  logic [retire_width-1:0][btb_index_bits-1:0] retire_btb_idx;

  // one read port per slot
  for (genvar i = 0; i < fetch_width; i++) begin : g_lookup
    logic [bht_index_bits-1:0] bht_idx;
    logic [btb_index_bits-1:0] btb_idx;

    assign bht_idx = slot_pc[i][bht_index_bits+1:2];
    assign btb_idx = slot_pc[i][btb_index_bits+1:2];
    // counter 2 or 3 and a tag hit
    assign hit_taken[i] = bht_count[bht_idx][1] && btb_valid[btb_idx] &&
                          (btb_tag[btb_idx] == slot_pc[i]);
    assign target[i] = btb_target[btb_idx];
  end

  for (genvar r = 0; r < retire_width; r++) begin : g_retire_idx
    assign retire_bht_idx[r] = retire[r].pc[bht_index_bits+1:2];
    assign retire_btb_idx[r] = retire[r].pc[btb_index_bits+1:2];
  end

  // training, counters saturate at 0 and 3
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int e = 0; e < bht_entries; e++) begin
        // weakly not taken
        bht_count[e] <= 2'd1;
      end
      for (int e = 0; e < btb_entries; e++) begin
        btb_valid[e] <= 1'b0;
      end
    end else begin
      for (int r = 0; r < retire_width; r++) begin
        if (retire[r].valid && retire[r].is_branch) begin
          if (retire[r].taken && bht_count[retire_bht_idx[r]] != 2'd3) begin
            bht_count[retire_bht_idx[r]] <= bht_count[retire_bht_idx[r]] + 2'd1;
          end else if (!retire[r].taken && bht_count[retire_bht_idx[r]] != 2'd0) begin
            bht_count[retire_bht_idx[r]] <= bht_count[retire_bht_idx[r]] - 2'd1;
          end
          if (retire[r].taken) begin
            btb_valid[retire_btb_idx[r]] <= 1'b1;
          end
        end
      end
    end
  end

  // btb payload, written only for taken outcomes
  always_ff @(posedge clock) begin
    for (int r = 0; r < retire_width; r++) begin
      if (retire[r].valid && retire[r].is_branch && retire[r].taken) begin
        btb_tag[retire_btb_idx[r]] <= retire[r].pc;
        btb_target[retire_btb_idx[r]] <= retire[r].target;
      end
    end
  end

  // backend retires each instruction once, so pcs in one cycle differ
  for (genvar a = 0; a < retire_width; a++) begin : g_retire_a
    for (genvar b = a + 1; b < retire_width; b++) begin : g_retire_b
      assert property (@(posedge clock) disable iff (reset)
        (retire[a].valid && retire[b].valid) |-> (retire[a].pc != retire[b].pc))
        else $error("retire entries %0d and %0d share pc %h", a, b, retire[a].pc);
    end
  end

endmodule

// File: line_predecoder.sv
/*
  splits a fetched line into slots and flags the control flow ones
  base_pc must be word aligned, jalr counts as a branch slot
*/
`timescale 1ns/1ns

module line_predecoder (
  input  logic [32*fetch_types_pkg::fetch_width-1:0]     line,
  input  logic [31:0]                                    base_pc,
  output logic [fetch_types_pkg::fetch_width-1:0][31:0]  slot_pc,
  output logic [fetch_types_pkg::fetch_width-1:0][31:0]  slot_inst,
  output logic [fetch_types_pkg::fetch_width-1:0]        is_branch
);

  import fetch_types_pkg::*;

  for (genvar i = 0; i < fetch_width; i++) begin : g_slot
    logic [6:0] opcode;

    // slot i sits in word i of the line
    assign slot_inst[i] = line[32*i +: 32];
    assign slot_pc[i] = base_pc + 32'(4 * i);

    // major opcode only
    assign opcode = slot_inst[i][6:0];
    assign is_branch[i] = (opcode == rv32_op_branch) ||
                          (opcode == rv32_op_jal) ||
                          (opcode == rv32_op_jalr);
  end

  // fetch address comes from the request stage, or from a redirect
  always_comb begin
    if (!$isunknown(base_pc)) begin
      assert (base_pc[1:0] == 2'b00)
        else $error("line base address %h is not word aligned", base_pc);
    end
  end

endmodule

// File: core_bus_pkg.sv
/*
  bus and backend interface types of the fetch unit
  APB is read only here, pslverr is not carried
*/
package core_bus_pkg;

  // retire updates the predictor sees per cycle
  localparam int retire_width = 2;

  typedef struct packed {
    logic        psel;
    logic        penable;
    // always 0, fetch only reads
    logic        pwrite;
    logic [31:0] paddr;
  } apb_req_t;

  typedef struct packed {
    logic         pready;
    // slot i in bits 32i+31 down to 32i
    logic [127:0] prdata;
  } apb_rsp_t;

  // resolved control flow instruction from the backend
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic        is_branch;
    logic        taken;
    logic [31:0] target;
  } retire_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } redirect_t;

endpackage

// File: fetch_types_pkg.sv
/*
  fetch side types and sizes for the RV32 front end
  no compressed instructions, every slot is one 32-bit word
  fetch_buffer_depth must stay a power of two
*/
package fetch_types_pkg;

  // slots per fetched line
  localparam int fetch_width = 4;

  // first fetch address out of reset
  localparam logic [31:0] reset_pc = 32'h0000_1000;

  // major opcodes that end a fetch line when predicted taken
  localparam logic [6:0] rv32_op_branch = 7'b1100011;
  localparam logic [6:0] rv32_op_jal = 7'b1101111;
  localparam logic [6:0] rv32_op_jalr = 7'b1100111;

  // bimodal table, indexed by pc[7:2]
  localparam int bht_entries = 64;
  localparam int bht_index_bits = $clog2(bht_entries);

  // target buffer, indexed by pc[5:2], full pc as tag
  localparam int btb_entries = 16;
  localparam int btb_index_bits = $clog2(btb_entries);

  // packets held between fetch and decode
  localparam int fetch_buffer_depth = 4;
  localparam int buffer_ptr_bits = $clog2(fetch_buffer_depth);

  // one instruction slot of a fetch packet
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        pred_taken;
    // zero unless pred_taken
    logic [31:0] pred_addr;
  } fetch_slot_t;

  // slot 0 holds the lowest address
  typedef fetch_slot_t [fetch_width-1:0] fetch_packet_t;

endpackage
